//--- dv/soc_bus_assert.sv
module soc_bus_assert (
    input logic              clk,
    input logic              reset,
    input logic              host_req,
    input bus_pkg::bus_req_t host_cmd,
    input logic              host_ack,
    input logic [1:0]        m_ack
);
    timeunit 1ns;
    timeprecision 100ps;

    int fails = 0;    // read by the testbench summary

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(host_ack) |-> host_req)
        else begin
            $error("host_ack rose while host_req was low");
            fails++;
        end

    cmd_stable: assert property (@(posedge clk) disable iff (reset)
        (host_req && !host_ack) |=> $stable(host_cmd))
        else begin
            $error("host_cmd changed while waiting for host_ack");
            fails++;
        end

    // never both masters, and no handover while the slave still acks
    one_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0(m_ack | $past(m_ack)))
        else begin
            $error("arbiter acked both masters together or back to back");
            fails++;
        end

endmodule

bind soc_bus_top soc_bus_assert bus_checks (
    .clk(clk), .reset(reset),
    .host_req(host_req), .host_cmd(host_cmd), .host_ack(host_ack), .m_ack(m_ack)
);

//--- dv/tb_soc_bus.sv
module tb_soc_bus;
    timeunit 1ns;
    timeprecision 100ps;

    import bus_pkg::*;
    import map_pkg::*;

    localparam int RAM_WORDS = 1024;
    // about 210 host cycles and 48 copied words, each with a generous worst case
    localparam int HOST_TRANS = 210;
    localparam int TRANS_CYCLES = 30;
    localparam int COPY_WORDS = 48;
    localparam int WORD_CYCLES = 16;
    localparam int MAX_CYCLES = 2 * (HOST_TRANS * TRANS_CYCLES + COPY_WORDS * WORD_CYCLES);

    logic        clk = 1'b0;
    logic        reset;
    logic        host_req;
    bus_req_t    host_cmd;
    logic        host_ack;
    bus_rsp_t    host_rsp;
    logic        copy_start;
    copy_cmd_t   copy_cmd;
    logic        copy_done;
    integer      seed;
    int          cycles = 0;
    int          data_errors = 0;
    int          done_errors = 0;
    logic [31:0] ram_model [RAM_WORDS];

    soc_bus_top #(.RAM_WORDS(RAM_WORDS)) UUT (
        .clk(clk), .reset(reset),
        .host_req(host_req), .host_cmd(host_cmd), .host_ack(host_ack), .host_rsp(host_rsp),
        .copy_start(copy_start), .copy_cmd(copy_cmd), .copy_done(copy_done)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic bus_rsp_t rsp_of(input logic [31:0] data);
        bus_rsp_t r;
        r.rdata = data;
        return r;
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    // plain repeated multiply, wraps at 32 bits
    function automatic logic [31:0] power_of(input logic [31:0] base, input logic [4:0] e);
        logic [31:0] r;
        r = 32'd1;
        for (int i = 0; i < int'(e); i++) begin
            r = r * base;
        end
        return r;
    endfunction

    function automatic logic [31:0] exp_reg_addr(input exp_reg_e r);
        return EXP_BASE | {28'd0, r, 2'b00};
    endfunction

    task automatic check_rsp(input string what, input bus_rsp_t got, input bus_rsp_t exp);
        if (got !== exp) begin
            $display("FAIL host_rsp.rdata %s: got %h expected %h", what, got.rdata, exp.rdata);
            data_errors++;
        end
    endtask

    task automatic check_done(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL copy_done %s: got %h expected %h", what, got, exp);
            done_errors++;
        end
    endtask

    // one full four-phase cycle on the host port
    task automatic host_cycle(input bus_op_e op, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] be,
                              output bus_rsp_t rsp);
        bus_req_t c;
        c.op = op;
        c.addr = addr;
        c.wdata = data;
        c.be = be;
        @(posedge clk);
        host_cmd <= c;
        host_req <= 1'b1;
        @(negedge clk);
        while (!host_ack) @(negedge clk);
        rsp = host_rsp;
        @(posedge clk);
        host_req <= 1'b0;
        @(negedge clk);
        while (host_ack) @(negedge clk);
    endtask

    task automatic host_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
        bus_rsp_t unused;
        host_cycle(op_write, addr, data, be, unused);
    endtask

    task automatic host_read(input logic [31:0] addr, output bus_rsp_t rsp);
        host_cycle(op_read, addr, 32'd0, 4'hf, rsp);
    endtask

    task automatic ram_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
        host_write(addr, data, be);
        ram_model[addr[11:2]] = merge_lanes(ram_model[addr[11:2]], data, be);
    endtask

    task automatic ram_check(input logic [31:0] addr, input string what);
        bus_rsp_t got;
        host_read(addr, got);
        check_rsp(what, got, rsp_of(ram_model[addr[11:2]]));
    endtask

    task automatic accel_run(input logic [31:0] base, input logic [4:0] e,
                             input logic check_busy);
        bus_rsp_t got;
        host_write(exp_reg_addr(reg_base), base, 4'hf);
        host_write(exp_reg_addr(reg_exp), {27'd0, e}, 4'hf);
        if (check_busy) begin
            host_read(exp_reg_addr(reg_status), got);
            check_rsp("status right after start", got, rsp_of(32'd1));
        end
        host_read(exp_reg_addr(reg_result), got);
        check_rsp("power result", got, rsp_of(power_of(base, e)));
    endtask

    task automatic copy_begin(input copy_cmd_t c);
        @(posedge clk);
        copy_cmd <= c;
        copy_start <= 1'b1;
        @(negedge clk);
        check_done("right after copy_start", copy_done, 1'b0);
    endtask

    task automatic copy_end(input copy_cmd_t c);
        logic [9:0] s;
        logic [9:0] d;
        @(negedge clk);
        while (!copy_done) @(negedge clk);
        @(negedge clk);
        check_done("held while copy_start high", copy_done, 1'b1);
        @(posedge clk);
        copy_start <= 1'b0;
        @(negedge clk);
        while (copy_done) @(negedge clk);
        s = c.src[11:2];
        d = c.dst[11:2];
        for (int i = 0; i < int'(c.count); i++) begin
            ram_model[d] = ram_model[s];    // forward, word by word
            s++;
            d++;
        end
    endtask

    task automatic test_ram();
        for (int i = 0; i < 16; i++) begin
            ram_write(RAM_BASE + 32'(i * 4), $random(seed), 4'hf);
        end
        for (int i = 0; i < 8; i++) begin
            ram_write(RAM_BASE + 32'(i * 8), $random(seed), 4'b0001 << (i % 4));
        end
        ram_write(RAM_BASE + 32'h04, $random(seed), 4'b0110);
        ram_write(RAM_BASE + 32'h0c, $random(seed), 4'b1001);
        for (int i = 0; i < 16; i++) begin
            ram_check(RAM_BASE + 32'(i * 4), "ram readback");
        end
    endtask

    task automatic test_unmapped();
        bus_rsp_t got;
        host_read(32'h0000_2000, got);
        check_rsp("unmapped read", got, rsp_of(32'd0));
        host_read(32'h0000_5004, got);
        check_rsp("unmapped read", got, rsp_of(32'd0));
        host_read(32'h0000_f00c, got);
        check_rsp("unmapped read", got, rsp_of(32'd0));
        host_write(32'h0000_3010, 32'hdead_beef, 4'hf);    // same low bits as ram word 4
        ram_check(RAM_BASE + 32'h10, "ram after unmapped write");
    endtask

    task automatic test_accel();
        logic [31:0] rnd;
        logic [4:0]  e;
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            e = (i == 0) ? 5'd0 : (i == 1) ? 5'd31 : (i == 2) ? 5'd1 : rnd[4:0];
            accel_run($random(seed), e, 1'b1);
        end
    endtask

    task automatic test_copy();
        copy_cmd_t c;
        for (int i = 0; i < 16; i++) begin
            ram_write(RAM_BASE + 32'h100 + 32'(i * 4), $random(seed), 4'hf);
        end
        c = '{src: 32'h100, dst: 32'h400, count: 8'd16};
        copy_begin(c);
        copy_end(c);
        for (int i = 0; i < 16; i++) begin
            ram_check(RAM_BASE + 32'h400 + 32'(i * 4), "copy destination");
        end
        for (int i = 0; i < 4; i++) begin
            ram_write(RAM_BASE + 32'h600 + 32'(i * 4), $random(seed), 4'hf);
        end
        c = '{src: 32'h100, dst: 32'h600, count: 8'd0};
        copy_begin(c);
        copy_end(c);
        for (int i = 0; i < 4; i++) begin
            ram_check(RAM_BASE + 32'h600 + 32'(i * 4), "after empty copy");
        end
    endtask

    task automatic test_concurrent();
        copy_cmd_t c;
        for (int i = 0; i < 32; i++) begin
            ram_write(RAM_BASE + 32'h800 + 32'(i * 4), $random(seed), 4'hf);
        end
        c = '{src: 32'h800, dst: 32'hc00, count: 8'd32};
        copy_begin(c);
        for (int i = 0; i < 8; i++) begin
            ram_write(RAM_BASE + 32'h200 + 32'(i * 4), $random(seed), 4'hf);
        end
        accel_run($random(seed), 5'd13, 1'b0);
        accel_run($random(seed), 5'd30, 1'b0);
        accel_run(32'd3, 5'd7, 1'b0);
        for (int i = 0; i < 8; i++) begin
            ram_check(RAM_BASE + 32'h200 + 32'(i * 4), "host area during copy");
        end
        copy_end(c);
        for (int i = 0; i < 32; i++) begin
            ram_check(RAM_BASE + 32'hc00 + 32'(i * 4), "copy destination under load");
        end
    endtask

    initial begin
        seed = 64;
        reset = 1'b1;
        host_req = 1'b0;
        host_cmd = '0;
        copy_start = 1'b0;
        copy_cmd = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_done("after reset", copy_done, 1'b0);
        test_ram();
        test_unmapped();
        test_accel();
        test_copy();
        test_concurrent();
        repeat (2) @(posedge clk);
        $display("errors: %0d data, %0d copy_done, %0d assertion",
                 data_errors, done_errors, UUT.bus_checks.fails);
        if (data_errors + done_errors + UUT.bus_checks.fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_soc_bus -f sources.f --Mdir obj_dir -o tb_soc_bus > build.log 2>&1 &&
    ./obj_dir/tb_soc_bus > sim.log 2>&1 ||
    echo "build or simulation stopped with an error, see build.log and sim.log"
grep -q "^Test OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sources.f
src/bus_pkg.sv
src/map_pkg.sv
src/bus_arbiter.sv
src/bus_decoder.sv
src/data_ram.sv
src/exp_accel.sv
src/copy_engine.sv
src/soc_bus_top.sv
dv/soc_bus_assert.sv
dv/tb_soc_bus.sv

//--- src/bus_arbiter.sv
module bus_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  logic [1:0]        m_req,
    input  bus_pkg::bus_req_t m_cmd [0:1],
    output logic [1:0]        m_ack,
    output bus_pkg::bus_rsp_t m_rsp,
    output logic              bus_req,
    output bus_pkg::bus_req_t bus_cmd,
    input  logic              bus_ack,
    input  bus_pkg::bus_rsp_t bus_rsp
);

    typedef enum logic [1:0] {
        st_idle,
        st_granted,
        st_release
    } state_e;

    state_e state;
    logic   last;      // granted master, also last served
    logic   winner;

    // on a tie the master not served last wins
    assign winner = (m_req == 2'b11) ? ~last : m_req[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            last  <= 1'b1;    // host wins the first tie
        end else begin
            case (state)
                st_idle: begin
                    if (|m_req) begin
                        last  <= winner;
                        state <= st_granted;
                    end
                end
                st_granted: begin
                    if (bus_ack) begin
                        state <= st_release;
                    end
                end
                st_release: begin
                    if (!bus_ack) begin
                        state <= st_idle;    // slave done, free the bus
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_comb begin
        bus_req = 1'b0;
        m_ack   = 2'b00;
        if (state != st_idle) begin
            bus_req     = m_req[last];
            m_ack[last] = bus_ack;
        end
    end

    assign bus_cmd = m_cmd[last];
    assign m_rsp   = bus_rsp;    // only the acked master looks at it

endmodule

//--- src/bus_decoder.sv
module bus_decoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              bus_req,
    input  bus_pkg::bus_req_t bus_cmd,
    output logic              bus_ack,
    output bus_pkg::bus_rsp_t bus_rsp,
    output logic              ram_req,
    output logic              exp_req,
    input  logic              ram_ack,
    input  logic              exp_ack,
    input  bus_pkg::bus_rsp_t ram_rsp,
    input  bus_pkg::bus_rsp_t exp_rsp
);
    import map_pkg::*;

    region_e region;      // from the current address
    region_e region_q;    // held for the whole cycle
    region_e sel;
    logic    active;
    logic    none_ack;

    always_comb begin
        if (bus_cmd.addr[15:12] == RAM_BASE[15:12]) begin
            region = region_ram;
        end else if (bus_cmd.addr[15:12] == EXP_BASE[15:12]) begin
            region = region_exp;
        end else begin
            region = region_none;
        end
    end

    assign sel = active ? region_q : region;

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            none_ack <= 1'b0;
        end else begin
            none_ack <= bus_req && (sel == region_none);    // unmapped, answer here
            if (bus_req && !active) begin
                active <= 1'b1;
            end else if (!bus_req && !bus_ack) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req && !active) begin
            region_q <= region;
        end
    end

    assign ram_req = bus_req && (sel == region_ram);
    assign exp_req = bus_req && (sel == region_exp);

    always_comb begin
        bus_ack = none_ack;
        bus_rsp = '0;    // zero for unmapped reads
        case (sel)
            region_ram: begin
                bus_ack = ram_ack;
                bus_rsp = ram_rsp;
            end
            region_exp: begin
                bus_ack = exp_ack;
                bus_rsp = exp_rsp;
            end
            default: ;
        endcase
    end

endmodule

//--- src/bus_pkg.sv
package bus_pkg;

    typedef enum logic {
        op_read,
        op_write
    } bus_op_e;

    // one bus request, held stable while req is high
    typedef struct packed {
        bus_op_e     op;
        logic [31:0] addr;    // byte address
        logic [31:0] wdata;
        logic [3:0]  be;      // byte lanes
    } bus_req_t;

    // valid while ack is high
    typedef struct packed {
        logic [31:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic [31:0] src;     // byte address
        logic [31:0] dst;     // byte address
        logic [7:0]  count;   // words
    } copy_cmd_t;

endpackage

//--- src/copy_engine.sv
module copy_engine (
    input  logic               clk,
    input  logic               reset,
    input  logic               copy_start,
    input  bus_pkg::copy_cmd_t copy_cmd,
    output logic               copy_done,
    output logic               req,
    output bus_pkg::bus_req_t  cmd,
    input  logic               ack,
    input  bus_pkg::bus_rsp_t  rsp
);
    import bus_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_rd,
        st_rd_wait,
        st_wr,
        st_wr_wait,
        st_finish
    } state_e;

    state_e      state;
    logic [31:0] src;
    logic [31:0] dst;
    logic [7:0]  left;      // words still to copy
    logic [31:0] data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (copy_start) begin
                        state <= (copy_cmd.count == 8'd0) ? st_finish : st_rd;
                    end
                end
                st_rd: begin
                    if (ack) begin
                        state <= st_rd_wait;
                    end
                end
                st_rd_wait: begin
                    if (!ack) begin
                        state <= st_wr;
                    end
                end
                st_wr: begin
                    if (ack) begin
                        state <= st_wr_wait;
                    end
                end
                st_wr_wait: begin
                    if (!ack) begin
                        state <= (left == 8'd1) ? st_finish : st_rd;
                    end
                end
                st_finish: begin
                    if (!copy_start) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && copy_start) begin
            src  <= copy_cmd.src;
            dst  <= copy_cmd.dst;
            left <= copy_cmd.count;
        end
        if (state == st_rd && ack) begin
            data_q <= rsp.rdata;
        end
        if (state == st_wr_wait && !ack) begin
            src  <= src + 32'd4;
            dst  <= dst + 32'd4;
            left <= left - 8'd1;
        end
    end

    assign req       = (state == st_rd) || (state == st_wr);
    assign copy_done = (state == st_finish);
    assign cmd.op    = (state == st_wr) ? op_write : op_read;
    assign cmd.addr  = (state == st_wr) ? dst : src;
    assign cmd.wdata = data_q;
    assign cmd.be    = 4'hf;    // whole words

endmodule

//--- src/data_ram.sv
module data_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    input  bus_pkg::bus_req_t cmd,
    output logic              ack,
    output bus_pkg::bus_rsp_t rsp
);
    import bus_pkg::*;

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] index;

    assign index = cmd.addr[AW+1:2];    // upper bits wrap

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= req;    // one cycle each way
        end
    end

    // act once, on the edge where ack rises
    always_ff @(posedge clk) begin
        if (req && !ack) begin
            if (cmd.op == op_write) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (cmd.be[lane]) begin
                        mem[index][8*lane +: 8] <= cmd.wdata[8*lane +: 8];
                    end
                end
            end
            rsp.rdata <= mem[index];
        end
    end

endmodule

//--- src/exp_accel.sv
module exp_accel (
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    input  bus_pkg::bus_req_t cmd,
    output logic              ack,
    output bus_pkg::bus_rsp_t rsp
);
    import bus_pkg::*;
    import map_pkg::*;

    typedef enum logic {
        st_idle,
        st_run
    } state_e;

    state_e      state;
    exp_reg_e    reg_sel;
    logic        busy;
    logic        take;       // cycle accepted this edge
    logic        start;
    logic [31:0] base_q;
    logic [4:0]  exp_q;
    logic [2:0]  bit_idx;
    logic [31:0] result;
    logic [31:0] square;

    assign reg_sel = exp_reg_e'(cmd.addr[3:2]);
    assign busy    = (state == st_run);
    assign square  = result * result;    // mod 2^32
    assign take    = req && !ack && !(cmd.op == op_read && reg_sel == reg_result && busy);
    assign start   = take && cmd.op == op_write && reg_sel == reg_exp && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            ack   <= 1'b0;
        end else begin
            if (!req) begin
                ack <= 1'b0;
            end else if (take) begin
                ack <= 1'b1;
            end
            if (start) begin
                state <= st_run;
            end else if (busy && bit_idx == 3'd0) begin
                state <= st_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && cmd.op == op_write && reg_sel == reg_base) begin
            base_q <= cmd.wdata;
        end
        if (start) begin
            exp_q   <= cmd.wdata[4:0];
            bit_idx <= 3'd4;
            result  <= 32'd1;
        end else if (busy) begin
            result  <= exp_q[bit_idx] ? square * base_q : square;    // msb first
            bit_idx <= bit_idx - 3'd1;
        end
        if (take) begin
            case (reg_sel)
                reg_result: rsp.rdata <= result;
                reg_status: rsp.rdata <= {31'd0, busy};
                default:    rsp.rdata <= '0;
            endcase
        end
    end

endmodule

//--- src/map_pkg.sv
package map_pkg;

    // regions are picked by address bits 15..12
    localparam logic [31:0] RAM_BASE = 32'h0000_0000;
    localparam logic [31:0] EXP_BASE = 32'h0000_1000;

    typedef enum logic [1:0] {
        region_ram,
        region_exp,
        region_none
    } region_e;

    // accelerator word offsets, address bits 3..2
    typedef enum logic [1:0] {
        reg_base,      // w: base operand
        reg_exp,       // w: exponent, starts a run
        reg_result,    // r: stalls until run ends
        reg_status     // r: bit 0 busy
    } exp_reg_e;

endpackage

//--- src/soc_bus_top.sv
module soc_bus_top #(
    parameter int RAM_WORDS = 1024
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               host_req,
    input  bus_pkg::bus_req_t  host_cmd,
    output logic               host_ack,
    output bus_pkg::bus_rsp_t  host_rsp,
    input  logic               copy_start,
    input  bus_pkg::copy_cmd_t copy_cmd,
    output logic               copy_done
);
    import bus_pkg::*;

    logic       dma_req;
    logic       dma_ack;
    bus_req_t   dma_cmd;
    bus_rsp_t   dma_rsp;
    logic [1:0] m_req;       // host is 0, copy engine is 1
    logic [1:0] m_ack;
    bus_req_t   m_cmd [0:1];
    bus_rsp_t   m_rsp;
    logic       bus_req;
    logic       bus_ack;
    bus_req_t   bus_cmd;
    bus_rsp_t   bus_rsp;
    logic       ram_req;
    logic       ram_ack;
    bus_rsp_t   ram_rsp;
    logic       exp_req;
    logic       exp_ack;
    bus_rsp_t   exp_rsp;

    assign m_req    = {dma_req, host_req};
    assign m_cmd[0] = host_cmd;
    assign m_cmd[1] = dma_cmd;
    assign host_ack = m_ack[0];
    assign dma_ack  = m_ack[1];
    assign host_rsp = m_rsp;
    assign dma_rsp  = m_rsp;

    bus_arbiter arbiter (
        .clk(clk), .reset(reset),
        .m_req(m_req), .m_cmd(m_cmd), .m_ack(m_ack), .m_rsp(m_rsp),
        .bus_req(bus_req), .bus_cmd(bus_cmd), .bus_ack(bus_ack), .bus_rsp(bus_rsp)
    );

    bus_decoder decoder (
        .clk(clk), .reset(reset),
        .bus_req(bus_req), .bus_cmd(bus_cmd), .bus_ack(bus_ack), .bus_rsp(bus_rsp),
        .ram_req(ram_req), .exp_req(exp_req), .ram_ack(ram_ack), .exp_ack(exp_ack),
        .ram_rsp(ram_rsp), .exp_rsp(exp_rsp)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) data_mem (
        .clk(clk), .reset(reset),
        .req(ram_req), .cmd(bus_cmd), .ack(ram_ack), .rsp(ram_rsp)
    );

    exp_accel exp_unit (
        .clk(clk), .reset(reset),
        .req(exp_req), .cmd(bus_cmd), .ack(exp_ack), .rsp(exp_rsp)
    );

    copy_engine dma (
        .clk(clk), .reset(reset),
        .copy_start(copy_start), .copy_cmd(copy_cmd), .copy_done(copy_done),
        .req(dma_req), .cmd(dma_cmd), .ack(dma_ack), .rsp(dma_rsp)
    );

endmodule
